//--- project.f
hdl/lbp_pkg.sv
hdl/lbpt_index_hash.sv
hdl/bram_2rport_1wport.sv
hdl/lbpt.sv
hdl/lht.sv
hdl/local_branch_predictor.sv
sim/lbp_assert.sv
sim/local_branch_predictor_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := local_branch_predictor_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS
SIM_ARGS  := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/local_branch_predictor_tb.sv
// Local branch predictor testbench: clock, reset, reference model, directed and random tests
`timescale 1ns/1ps

module local_branch_predictor_tb
    import lbp_pkg::*;
();

    localparam int LH_LENGTH       = 8;
    localparam int SET_INDEX_WIDTH = 6;
    localparam int LOG_ENTRIES     = 3;
    localparam int LHT_INDEX_WIDTH = 6;
    localparam int IDX_W           = SET_INDEX_WIDTH + LOG_ENTRIES;
    localparam int CLK_PERIOD      = 100;
    localparam int ALT_UPDATES     = 40;
    localparam int RANDOM_CYCLES   = 400;
    // Directed phases take under 40 cycles beside the alternating run
    localparam int TEST_CYCLES     = 40 + ALT_UPDATES + RANDOM_CYCLES;

    logic                  CLK;
    logic                  nRST;
    logic                  valid_resp;
    logic [PC_WIDTH-1:0]   pc_resp;
    logic [ASID_WIDTH-1:0] asid_resp;
    logic                  pred_taken_restart;
    logic                  update_valid;
    logic [PC_WIDTH-1:0]   update_pc;
    logic [ASID_WIDTH-1:0] update_asid;
    logic                  update_taken;
    logic                  update_correct;

    // Reference model state
    logic [LH_LENGTH-1:0]  hist_model [2**LHT_INDEX_WIDTH];
    logic [1:0]            ctr_stored [2**IDX_W];
    logic [1:0]            ctr_latest [2**IDX_W];
    logic                  pend_valid;
    logic [IDX_W-1:0]      pend_idx;
    logic [1:0]            pend_ctr;
    logic [31:0]           seed;
    int                    correct_run;

    local_branch_predictor dut0 (.*);

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic value_error(input string name, input logic exp, input logic act);
        report_failure($sformatf("Error at %0t ns: %s expected %0b, got %0b",
                                 $time, name, exp, act));
    endtask

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Set and entry as one flat index, using the history before this cycle's shift
    function automatic logic [IDX_W-1:0] table_index(input logic [PC_WIDTH-1:0] pc,
                                                     input logic [ASID_WIDTH-1:0] asid);
        logic [LH_LENGTH-1:0] lh;
        lh = hist_model[pc[PC_OFFSET +: LHT_INDEX_WIDTH]];
        return pc[PC_OFFSET +: IDX_W] ^ IDX_W'(lh) ^ IDX_W'(asid);
    endfunction

    function automatic logic [1:0] step_counter(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == CTR_SN) ? CTR_WN : CTR_ST;
        end
        return (ctr == CTR_ST) ? CTR_WT : CTR_SN;
    endfunction

    // One clock cycle: drive, advance the model over the edge, check the outputs
    task automatic run_cycle(input logic fv, input logic [PC_WIDTH-1:0] fpc,
                             input logic [ASID_WIDTH-1:0] fasid, input logic uv,
                             input logic [PC_WIDTH-1:0] upc,
                             input logic [ASID_WIDTH-1:0] uasid, input logic ut);
        logic                       exp_pred;
        logic                       exp_correct;
        logic [IDX_W-1:0]           uidx;
        logic [LHT_INDEX_WIDTH-1:0] hidx;
        logic [1:0]                 old_ctr;
        valid_resp   = fv;
        pc_resp      = fpc;
        asid_resp    = fasid;
        update_valid = uv;
        update_pc    = upc;
        update_asid  = uasid;
        update_taken = ut;
        // Fetch reads the memory before the pending U1 write lands
        exp_pred = ctr_stored[table_index(fpc, fasid)][1];
        if (pend_valid) begin
            ctr_stored[pend_idx] = pend_ctr;
        end
        pend_valid  = uv;
        exp_correct = 1'b0;
        if (uv) begin
            uidx             = table_index(upc, uasid);
            hidx             = upc[PC_OFFSET +: LHT_INDEX_WIDTH];
            old_ctr          = ctr_latest[uidx];
            exp_correct      = old_ctr[1] == ut;
            ctr_latest[uidx] = step_counter(old_ctr, ut);
            pend_idx         = uidx;
            pend_ctr         = ctr_latest[uidx];
            hist_model[hidx] = {hist_model[hidx][LH_LENGTH-2:0], ut};
        end
        @(posedge CLK);
        #5;
        if (fv) begin
            assert (pred_taken_restart === exp_pred)
            else value_error("pred_taken_restart", exp_pred, pred_taken_restart);
        end
        if (uv) begin
            assert (update_correct === exp_correct)
            else value_error("update_correct", exp_correct, update_correct);
            correct_run = update_correct ? correct_run + 1 : 0;
        end
    endtask

    task automatic fetch(input logic [PC_WIDTH-1:0] pc, input logic [ASID_WIDTH-1:0] asid);
        run_cycle(1'b1, pc, asid, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic resolve(input logic [PC_WIDTH-1:0] pc, input logic [ASID_WIDTH-1:0] asid,
                           input logic taken);
        run_cycle(1'b0, '0, '0, 1'b1, pc, asid, taken);
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        seed         = 32'h27cf_8674;
        nRST         = 1'b0;
        valid_resp   = 1'b0;
        pc_resp      = '0;
        asid_resp    = '0;
        update_valid = 1'b0;
        update_pc    = '0;
        update_asid  = '0;
        update_taken = 1'b0;
        pend_valid   = 1'b0;
        pend_idx     = '0;
        pend_ctr     = CTR_SN;
        correct_run  = 0;
        foreach (hist_model[i]) hist_model[i] = '0;
        foreach (ctr_stored[i]) ctr_stored[i] = CTR_SN;
        foreach (ctr_latest[i]) ctr_latest[i] = CTR_SN;
        repeat (10) @(posedge CLK);
        #5;
        nRST = 1'b1;

        // Fresh table predicts not-taken everywhere
        fetch(32'h0000_0480, 9'd0);
        fetch(32'h0000_0484, 9'd3);
        fetch(32'h0000_1a00, 9'd7);
        resolve(32'h0000_0480, 9'd0, 1'b0);
        resolve(32'h0000_0484, 9'd0, 1'b1);

        // Always-taken branch, history saturates to all ones
        repeat (LH_LENGTH + 2) resolve(32'h0000_1040, 9'd5, 1'b1);
        idle(1);
        fetch(32'h0000_1040, 9'd5);
        assert (pred_taken_restart) else report_failure("Always-taken branch not predicted taken");
        fetch(32'h0000_1040, 9'd6);

        // Same entry of set 0x18 back to back, then two entries interleaved
        resolve(32'h0000_0300, 9'd0, 1'b1);
        resolve(32'h0000_0304, 9'd1, 1'b1);
        resolve(32'h0000_0308, 9'd2, 1'b1);
        resolve(32'h0000_0310, 9'd0, 1'b1);
        resolve(32'h0000_0314, 9'd0, 1'b1);
        resolve(32'h0000_0318, 9'd2, 1'b1);
        resolve(32'h0000_031c, 9'd2, 1'b1);
        idle(1);
        fetch(32'h0000_030c, 9'd3);
        fetch(32'h0000_0320, 9'd12);
        fetch(32'h0000_0320, 9'd13);

        // Alternating branch
        correct_run = 0;
        for (int i = 0; i < ALT_UPDATES; i++) begin
            resolve(32'h0000_20c0, 9'd1, i[0]);
        end
        assert (correct_run >= 16) else report_failure("Alternating branch still mispredicted");

        // Fetch and update of one counter in the same cycle
        resolve(32'h0000_07a0, 9'd0, 1'b1);
        idle(1);
        run_cycle(1'b1, 32'h0000_07a0, 9'd1, 1'b1, 32'h0000_07a0, 9'd1, 1'b1);
        assert (!pred_taken_restart) else report_failure("Same-cycle fetch saw the new counter");
        idle(1);
        fetch(32'h0000_07a0, 9'd3);

        // Random traffic over eight PCs and four ASIDs
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = next_random();
            run_cycle(r[31], 32'h0000_4000 | {27'd0, r[30:28], 2'b00}, {7'd0, r[27:26]},
                      r[18], 32'h0000_4000 | {27'd0, r[24:22], 2'b00}, {7'd0, r[21:20]},
                      r[19]);
        end
        idle(3);

        if (dut0.lbp_assert0.fail_count != 0) begin
            report_failure("A port assertion bound into the DUT failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    always @(posedge CLK) begin
        if (dut0.lbp_assert0.fail_count != 0) begin
            report_failure("A port assertion bound into the DUT failed");
        end
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (10 + TEST_CYCLES + 50));
        report_failure("Timeout: the tests did not finish in time");
    end

endmodule

//--- sim/lbp_assert.sv
// Concurrent assertions on the local branch predictor ports and their bind
`timescale 1ns/1ps

module lbp_assert (
    input logic CLK,
    input logic nRST,
    input logic update_valid,
    input logic pred_taken_restart,
    input logic update_correct
);

    // Failed check count
    int fail_count = 0;

    // ----------------------------------------------------------------------
    // Port checks
    // ----------------------------------------------------------------------

    outputs_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown({pred_taken_restart, update_correct}))
    else begin
        fail_count++;
        $error("Predictor output is unknown outside reset");
    end

    // First cycle out of reset has no prediction
    pred_low_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !pred_taken_restart)
    else begin
        fail_count++;
        $error("pred_taken_restart high in the first cycle after reset");
    end

    correct_known_after_update: assert property (@(posedge CLK) disable iff (!nRST)
        $past(update_valid) |-> !$isunknown(update_correct))
    else begin
        fail_count++;
        $error("update_correct unknown after an update");
    end

endmodule

bind local_branch_predictor lbp_assert lbp_assert0 (
    .CLK               (CLK),
    .nRST              (nRST),
    .update_valid      (update_valid),
    .pred_taken_restart(pred_taken_restart),
    .update_correct    (update_correct)
);

//--- hdl/local_branch_predictor.sv
// Local branch predictor top level: LHT feeding the LBPT, parameters passed down
`timescale 1ns/1ps

module local_branch_predictor
    import lbp_pkg::*;
#(
    parameter int LH_LENGTH       = 8,
    parameter int SET_INDEX_WIDTH = 6,
    parameter int LOG_ENTRIES     = 3,
    parameter int LHT_INDEX_WIDTH = 6
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // Fetch side
    input  logic                  valid_resp,
    input  logic [PC_WIDTH-1:0]   pc_resp,
    input  logic [ASID_WIDTH-1:0] asid_resp,
    output logic                  pred_taken_restart,

    // Resolve side
    input  logic                  update_valid,
    input  logic [PC_WIDTH-1:0]   update_pc,
    input  logic [ASID_WIDTH-1:0] update_asid,
    input  logic                  update_taken,
    output logic                  update_correct
);

    logic [LH_LENGTH-1:0] lh_resp;
    logic [LH_LENGTH-1:0] update_lh;

    lht #(
        .LH_LENGTH      (LH_LENGTH),
        .LHT_INDEX_WIDTH(LHT_INDEX_WIDTH)
    ) lht0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .pc_resp     (pc_resp),
        .lh_resp     (lh_resp),
        .update_valid(update_valid),
        .update_pc   (update_pc),
        .update_taken(update_taken),
        .update_lh   (update_lh)
    );

    // History seen by the update is the one before its own outcome
    lbpt #(
        .LH_LENGTH      (LH_LENGTH),
        .SET_INDEX_WIDTH(SET_INDEX_WIDTH),
        .LOG_ENTRIES    (LOG_ENTRIES)
    ) lbpt0 (
        .CLK               (CLK),
        .nRST              (nRST),
        .valid_resp        (valid_resp),
        .pc_resp           (pc_resp),
        .lh_resp           (lh_resp),
        .asid_resp         (asid_resp),
        .pred_taken_restart(pred_taken_restart),
        .update0_valid     (update_valid),
        .update0_pc        (update_pc),
        .update0_lh        (update_lh),
        .update0_asid      (update_asid),
        .update0_taken     (update_taken),
        .update1_correct   (update_correct)
    );

endmodule

//--- hdl/lht.sv
// Local history table: per-address outcome shift registers with fetch and update reads
`timescale 1ns/1ps

module lht
    import lbp_pkg::*;
#(
    parameter int LH_LENGTH       = 8,
    parameter int LHT_INDEX_WIDTH = 6
) (
    input  logic                 CLK,
    input  logic                 nRST,

    // Fetch read
    input  logic [PC_WIDTH-1:0]  pc_resp,
    output logic [LH_LENGTH-1:0] lh_resp,

    // Update read and shift
    input  logic                 update_valid,
    input  logic [PC_WIDTH-1:0]  update_pc,
    input  logic                 update_taken,
    output logic [LH_LENGTH-1:0] update_lh
);

    localparam int LHT_ENTRIES = 2 ** LHT_INDEX_WIDTH;

    logic [LHT_INDEX_WIDTH-1:0] resp_index;
    logic [LHT_INDEX_WIDTH-1:0] update_index;
    logic [LH_LENGTH-1:0]       histories [LHT_ENTRIES];

    // ----------------------------------------------------------------------
    // Indexing
    // ----------------------------------------------------------------------

    // Both ports index by the aligned PC bits
    assign resp_index   = pc_resp[PC_OFFSET +: LHT_INDEX_WIDTH];
    assign update_index = update_pc[PC_OFFSET +: LHT_INDEX_WIDTH];

    // Reads see the history as it stands before this cycle's shift
    assign lh_resp   = histories[resp_index];
    assign update_lh = histories[update_index];

    // ----------------------------------------------------------------------
    // History registers
    // ----------------------------------------------------------------------

    genvar i;
    generate
        for (i = 0; i < LHT_ENTRIES; i++) begin : g_hist
            logic hit;

            assign hit = update_valid && (update_index == LHT_INDEX_WIDTH'(i));

            // Newest outcome enters at bit 0, oldest drops off the top
            always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                    histories[i] <= '0;
                end else if (hit) begin
                    histories[i] <= {histories[i][LH_LENGTH-2:0], update_taken};
                end
            end
        end
    endgenerate

endmodule

//--- hdl/lbpt.sv
// Local branch prediction table: RESP/RESTART prediction and two-stage counter update
`timescale 1ns/1ps

module lbpt
    import lbp_pkg::*;
#(
    parameter int LH_LENGTH       = 8,
    parameter int SET_INDEX_WIDTH = 6,
    parameter int LOG_ENTRIES     = 3
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // RESP stage
    input  logic                  valid_resp,
    input  logic [PC_WIDTH-1:0]   pc_resp,
    input  logic [LH_LENGTH-1:0]  lh_resp,
    input  logic [ASID_WIDTH-1:0] asid_resp,

    // RESTART stage
    output logic                  pred_taken_restart,

    // Update 0
    input  logic                  update0_valid,
    input  logic [PC_WIDTH-1:0]   update0_pc,
    input  logic [LH_LENGTH-1:0]  update0_lh,
    input  logic [ASID_WIDTH-1:0] update0_asid,
    input  logic                  update0_taken,

    // Update 1
    output logic                  update1_correct
);

    localparam int ENTRIES = 2 ** LOG_ENTRIES;
    localparam int SETS    = 2 ** SET_INDEX_WIDTH;

    // ----------------------------------------------------------------------
    // Prediction path
    // ----------------------------------------------------------------------

    logic [SET_INDEX_WIDTH-1:0]  set_resp;
    logic [LOG_ENTRIES-1:0]      entry_resp;
    logic [LOG_ENTRIES-1:0]      entry_restart;
    logic [ENTRIES-1:0][1:0]     set_restart;

    lbpt_index_hash #(
        .LH_LENGTH      (LH_LENGTH),
        .SET_INDEX_WIDTH(SET_INDEX_WIDTH),
        .LOG_ENTRIES    (LOG_ENTRIES)
    ) resp_hash (
        .pc   (pc_resp),
        .lh   (lh_resp),
        .asid (asid_resp),
        .index({set_resp, entry_resp})
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            entry_restart <= '0;
        end else begin
            entry_restart <= entry_resp;
        end
    end

    assign pred_taken_restart = set_restart[entry_restart][1];

    // ----------------------------------------------------------------------
    // Update path
    // ----------------------------------------------------------------------

    logic [SET_INDEX_WIDTH-1:0]  update0_set;
    logic [LOG_ENTRIES-1:0]      update0_entry;

    logic                        update1_valid;
    logic [SET_INDEX_WIDTH-1:0]  update1_set;
    logic [LOG_ENTRIES-1:0]      update1_entry;
    logic                        update1_taken;
    logic [ENTRIES-1:0][1:0]     update1_read_set;
    logic [ENTRIES-1:0][1:0]     update1_old_set;
    logic [ENTRIES-1:0][1:0]     update1_new_set;
    logic [1:0]                  update1_old_ctr;

    // Previous U1 wrote the set this U1 read, at the same edge
    logic                        last_conflict;
    logic [ENTRIES-1:0][1:0]     last_new_set;

    lbpt_index_hash #(
        .LH_LENGTH      (LH_LENGTH),
        .SET_INDEX_WIDTH(SET_INDEX_WIDTH),
        .LOG_ENTRIES    (LOG_ENTRIES)
    ) update_hash (
        .pc   (update0_pc),
        .lh   (update0_lh),
        .asid (update0_asid),
        .index({update0_set, update0_entry})
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
            update1_set   <= '0;
            update1_entry <= '0;
            update1_taken <= 1'b0;
            last_conflict <= 1'b0;
            last_new_set  <= '0;
        end else begin
            update1_valid <= update0_valid;
            update1_set   <= update0_set;
            update1_entry <= update0_entry;
            update1_taken <= update0_taken;
            last_conflict <= update0_valid && update1_valid && (update0_set == update1_set);
            last_new_set  <= update1_new_set;
        end
    end

    // Stale read replaced by the set written last cycle
    assign update1_old_set = last_conflict ? last_new_set : update1_read_set;
    assign update1_old_ctr = update1_old_set[update1_entry];
    assign update1_correct = update1_old_ctr[1] == update1_taken;

    // Saturating step of the addressed counter only
    always_comb begin
        update1_new_set = update1_old_set;
        case (update1_old_ctr)
            CTR_SN:  update1_new_set[update1_entry] = update1_taken ? CTR_WN : CTR_SN;
            CTR_WN:  update1_new_set[update1_entry] = update1_taken ? CTR_ST : CTR_SN;
            CTR_WT:  update1_new_set[update1_entry] = update1_taken ? CTR_ST : CTR_SN;
            CTR_ST:  update1_new_set[update1_entry] = update1_taken ? CTR_ST : CTR_WT;
            default: update1_new_set[update1_entry] = CTR_SN;
        endcase
    end

    // ----------------------------------------------------------------------
    // Counter memory, one row per set
    // ----------------------------------------------------------------------

    bram_2rport_1wport #(
        .INNER_WIDTH(ENTRIES * 2),
        .OUTER_WIDTH(SETS)
    ) counter_mem (
        .CLK         (CLK),
        .nRST        (nRST),
        .port0_ren   (valid_resp),
        .port0_rindex(set_resp),
        .port0_rdata (set_restart),
        .port1_ren   (update0_valid),
        .port1_rindex(update0_set),
        .port1_rdata (update1_read_set),
        .wen         (update1_valid),
        .windex      (update1_set),
        .wdata       (update1_new_set)
    );

endmodule

//--- hdl/bram_2rport_1wport.sv
// Synchronous-read memory with two independent read ports and one write port
`timescale 1ns/1ps

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           nRST,

    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    input  logic                           wen,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ----------------------------------------------------------------------
    // Array and read registers
    // ----------------------------------------------------------------------

    // Reads sample the array before this edge's write lands,
    // so a same-index read and write returns the old row
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
            if (wen) begin
                mem[windex] <= wdata;
            end
        end
    end

endmodule

//--- hdl/lbpt_index_hash.sv
// XOR hash of PC, local history and ASID into a combined LBPT set and entry index
`timescale 1ns/1ps

module lbpt_index_hash
    import lbp_pkg::*;
#(
    parameter int LH_LENGTH       = 8,
    parameter int SET_INDEX_WIDTH = 6,
    parameter int LOG_ENTRIES     = 3
) (
    input  logic [PC_WIDTH-1:0]                      pc,
    input  logic [LH_LENGTH-1:0]                     lh,
    input  logic [ASID_WIDTH-1:0]                    asid,
    output logic [SET_INDEX_WIDTH+LOG_ENTRIES-1:0]   index
);

    localparam int INDEX_WIDTH = SET_INDEX_WIDTH + LOG_ENTRIES;

    logic [INDEX_WIDTH-1:0] pc_bits;
    logic [INDEX_WIDTH-1:0] lh_bits;
    logic [INDEX_WIDTH-1:0] asid_bits;

    // Skip the alignment bits, then take one index worth of PC
    assign pc_bits = pc[PC_OFFSET +: INDEX_WIDTH];

    // History and ASID zero-extended (or cut) to the index width
    assign lh_bits   = INDEX_WIDTH'(lh);
    assign asid_bits = INDEX_WIDTH'(asid);

    // Upper bits select the set, lower bits the counter in the set
    assign index = pc_bits ^ lh_bits ^ asid_bits;

endmodule

//--- hdl/lbp_pkg.sv
// Address and ASID widths, PC alignment offset and two-bit counter state encodings

package lbp_pkg;

    // ----------------------------------------------------------------------
    // Address widths
    // ----------------------------------------------------------------------

    // Fetch and branch address width
    localparam int PC_WIDTH = 32;

    // Address space ID width
    localparam int ASID_WIDTH = 9;

    // Low PC bits below instruction alignment, skipped by every index
    localparam int PC_OFFSET = 2;

    // ----------------------------------------------------------------------
    // Two-bit saturating counter states
    // ----------------------------------------------------------------------

    // Bit 1 is the taken prediction
    // Counters come out of reset as strongly not-taken

    // Strongly not-taken
    localparam logic [1:0] CTR_SN = 2'd0;

    // Weakly not-taken
    localparam logic [1:0] CTR_WN = 2'd1;

    // Weakly taken
    localparam logic [1:0] CTR_WT = 2'd2;

    // Strongly taken
    localparam logic [1:0] CTR_ST = 2'd3;

endpackage
